// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= issue_read_operands_tb
FLIST     ?= issue_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== issue_stage.f ====
+incdir+logic
logic/issue_pkg.sv
logic/issue_regfile.sv
logic/issue_hazard_check.sv
logic/issue_operand_select.sv
logic/issue_dispatch.sv
logic/issue_read_operands.sv
verification/issue_read_operands_assert.sv
verification/issue_read_operands_tb.sv

// ==== logic/issue_consts.svh ====
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// ------------------------------
// datapath widths
// ------------------------------
// data and pc share one width
`define ISSUE_XLEN 32
// integer register index
`define ISSUE_REG_ADDR_W 5

// ------------------------------
// counts
// ------------------------------
`define ISSUE_NR_REGS 32
`define ISSUE_NR_COMMIT 2
// scoreboard tag
`define ISSUE_TRANS_ID_W 3

`endif

// ==== logic/issue_dispatch.sv ====
`timescale 1ns/1ns
`include "issue_consts.svh"

module issue_dispatch (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  issue_pkg::issue_entry_t instr_i,
  // valid and ack seen together
  input  logic                    accept_i,
  input  logic [`ISSUE_XLEN-1:0]  operand_a_i,
  input  logic [`ISSUE_XLEN-1:0]  operand_b_i,
  input  logic [`ISSUE_XLEN-1:0]  imm_i,
  output issue_pkg::fu_data_t     fu_data_o,
  output issue_pkg::unit_valid_t  unit_valid_o,
  output logic [`ISSUE_XLEN-1:0]  pc_o,
  output logic                    is_compressed_o,
  output logic                    mult_busy_o
);

  import issue_pkg::*;

  unit_valid_t unit_valid_q;

  // ------------------------------
  // id/ex payload register
  // ------------------------------
  // loaded every cycle, only the strobes qualify it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fu_data_o.fu        <= NONE;
      fu_data_o.op        <= ADD;
      fu_data_o.operand_a <= '0;
      fu_data_o.operand_b <= '0;
      fu_data_o.imm       <= '0;
      fu_data_o.trans_id  <= '0;
      pc_o                <= '0;
      is_compressed_o     <= 1'b0;
    end else begin
      fu_data_o.fu        <= instr_i.fu;
      fu_data_o.op        <= instr_i.op;
      fu_data_o.operand_a <= operand_a_i;
      fu_data_o.operand_b <= operand_b_i;
      fu_data_o.imm       <= imm_i;
      fu_data_o.trans_id  <= instr_i.trans_id;
      pc_o                <= instr_i.pc;
      is_compressed_o     <= instr_i.is_compressed;
    end
  end

  // ------------------------------
  // unit valid strobes
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_valid_q <= '0;
    end else begin
      // single cycle pulse by default
      unit_valid_q <= '0;
      // an excepting instruction is retired without execution
      if (accept_i && !instr_i.ex_valid) begin
        case (instr_i.fu)
          ALU:         unit_valid_q.alu    <= 1'b1;
          CTRL_FLOW:   unit_valid_q.branch <= 1'b1;
          LOAD, STORE: unit_valid_q.lsu    <= 1'b1;
          MULT:        unit_valid_q.mult   <= 1'b1;
          CSR:         unit_valid_q.csr    <= 1'b1;
          default:     unit_valid_q        <= '0;
        endcase
      end
      // flush kills whatever was just issued
      if (flush_i) begin
        unit_valid_q <= '0;
      end
    end
  end

  assign unit_valid_o = unit_valid_q;
  // feeds the result bus contention check
  assign mult_busy_o  = unit_valid_q.mult;

endmodule

// ==== logic/issue_hazard_check.sv ====
`timescale 1ns/1ns
`include "issue_consts.svh"

module issue_hazard_check (
  input  issue_pkg::issue_entry_t                        instr_i,
  input  logic                                           valid_i,
  input  logic                                           stall_i,
  input  issue_pkg::clobber_table_t                      clobber_i,
  input  issue_pkg::fwd_value_t                          rs1_fwd_i,
  input  issue_pkg::fwd_value_t                          rs2_fwd_i,
  input  issue_pkg::unit_ready_t                         ready_i,
  input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0] commit_i,
  // a multiply was issued last cycle
  input  logic                                           mult_busy_i,
  output logic                                           ack_o,
  output issue_pkg::fwd_sel_t                            fwd_o
);

  import issue_pkg::*;

  fu_t  rs1_clob;
  fu_t  rs2_clob;
  fu_t  rd_clob;
  logic stall;
  logic fu_busy;
  logic rd_commit;

  // pending writers of each register
  assign rs1_clob = clobber_i[instr_i.rs1];
  assign rs2_clob = clobber_i[instr_i.rs2];
  assign rd_clob  = clobber_i[instr_i.rd];

  // ------------------------------
  // source operand availability
  // ------------------------------
  always_comb begin
    stall = stall_i;
    fwd_o = '0;
    // zimm uses the rs1 field as data, nothing to wait for
    if (!instr_i.use_zimm && (rs1_clob != NONE)) begin
      // csr results only arrive through the register file
      if (rs1_fwd_i.valid && (rs1_clob != CSR)) begin
        fwd_o.fwd_rs1 = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
    if (rs2_clob != NONE) begin
      if (rs2_fwd_i.valid && (rs2_clob != CSR)) begin
        fwd_o.fwd_rs2 = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
  end

  // busy flag of the unit this instruction needs
  always_comb begin
    unique case (instr_i.fu)
      ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~ready_i.flu;
      LOAD, STORE:               fu_busy = ~ready_i.lsu;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // commit retires rd in this very cycle
  always_comb begin
    rd_commit = 1'b0;
    for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
      if (commit_i[p].we && (commit_i[p].waddr == instr_i.rd)) begin
        rd_commit = 1'b1;
      end
    end
  end

  // ------------------------------
  // issue decision
  // ------------------------------
  always_comb begin
    ack_o = 1'b0;
    if (valid_i) begin
      // waw check on rd, a same-cycle commit frees it
      if (!stall && !fu_busy && ((rd_clob == NONE) || rd_commit)) begin
        ack_o = 1'b1;
      end
      // exceptions and unit-less instructions just pass
      if (instr_i.ex_valid || (instr_i.fu == NONE)) begin
        ack_o = 1'b1;
      end
    end
    // the fixed latency result bus is taken by the multiply
    if (mult_busy_i && (instr_i.fu inside {ALU, CTRL_FLOW, CSR})) begin
      ack_o = 1'b0;
    end
  end

endmodule

// ==== logic/issue_operand_select.sv ====
`timescale 1ns/1ns
`include "issue_consts.svh"

module issue_operand_select (
  input  issue_pkg::issue_entry_t instr_i,
  input  issue_pkg::fwd_sel_t     fwd_i,
  input  issue_pkg::fwd_value_t   rs1_fwd_i,
  input  issue_pkg::fwd_value_t   rs2_fwd_i,
  // register file read data
  input  logic [`ISSUE_XLEN-1:0]  rf_a_i,
  input  logic [`ISSUE_XLEN-1:0]  rf_b_i,
  output logic [`ISSUE_XLEN-1:0]  operand_a_o,
  output logic [`ISSUE_XLEN-1:0]  operand_b_o,
  output logic [`ISSUE_XLEN-1:0]  imm_o
);

  import issue_pkg::*;

  // ------------------------------
  // operand a
  // ------------------------------
  // later checks override earlier ones
  always_comb begin
    operand_a_o = rf_a_i;
    if (fwd_i.fwd_rs1) begin
      operand_a_o = rs1_fwd_i.value;
    end
    // auipc, jal and friends
    if (instr_i.use_pc) begin
      operand_a_o = instr_i.pc;
    end
    // csr immediate, zero extended rs1 index
    if (instr_i.use_zimm) begin
      operand_a_o = {{(`ISSUE_XLEN - `ISSUE_REG_ADDR_W){1'b0}}, instr_i.rs1};
    end
  end

  // ------------------------------
  // operand b
  // ------------------------------
  always_comb begin
    operand_b_o = rf_b_i;
    if (fwd_i.fwd_rs2) begin
      operand_b_o = rs2_fwd_i.value;
    end
    // stores and branches need rs2, their immediate goes via imm
    if (instr_i.use_imm && (instr_i.fu != STORE) && (instr_i.fu != CTRL_FLOW)) begin
      operand_b_o = instr_i.result;
    end
  end

  // immediate always travels on its own
  assign imm_o = instr_i.result;

endmodule

// ==== logic/issue_pkg.sv ====
`include "issue_consts.svh"

package issue_pkg;

  // target functional unit of an instruction
  typedef enum logic [2:0] {
    NONE      = 3'd0,
    LOAD      = 3'd1,
    STORE     = 3'd2,
    ALU       = 3'd3,
    CTRL_FLOW = 3'd4,
    MULT      = 3'd5,
    CSR       = 3'd6
  } fu_t;

  // operation code, carried to the unit untouched
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    XORL = 4'd2,
    ORL  = 4'd3,
    ANDL = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLTS = 4'd8,
    SLTU = 4'd9,
    EQ   = 4'd10,
    NE   = 4'd11,
    LW   = 4'd12,
    SW   = 4'd13,
    MUL  = 4'd14,
    CSRW = 4'd15
  } fu_op_t;

  // decoded instruction from the scoreboard
  typedef struct packed {
    logic [`ISSUE_XLEN-1:0]       pc;
    logic [`ISSUE_TRANS_ID_W-1:0] trans_id;
    fu_t                          fu;
    fu_op_t                       op;
    logic [`ISSUE_REG_ADDR_W-1:0] rs1;
    logic [`ISSUE_REG_ADDR_W-1:0] rs2;
    logic [`ISSUE_REG_ADDR_W-1:0] rd;
    // immediate lives here
    logic [`ISSUE_XLEN-1:0]       result;
    logic                         use_imm;
    logic                         use_zimm;
    logic                         use_pc;
    logic                         ex_valid;
    logic                         is_compressed;
  } issue_entry_t;

  // one writer unit per register, NONE when free
  typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_table_t;

  // scoreboard value for one source
  typedef struct packed {
    logic [`ISSUE_XLEN-1:0] value;
    logic                   valid;
  } fwd_value_t;

  typedef struct packed {
    logic                         we;
    logic [`ISSUE_REG_ADDR_W-1:0] waddr;
    logic [`ISSUE_XLEN-1:0]       wdata;
  } commit_port_t;

  typedef struct packed {
    logic flu;
    logic lsu;
  } unit_ready_t;

  typedef struct packed {
    logic alu;
    logic branch;
    logic lsu;
    logic mult;
    logic csr;
  } unit_valid_t;

  // bundle handed to execute
  typedef struct packed {
    fu_t                          fu;
    fu_op_t                       op;
    logic [`ISSUE_XLEN-1:0]       operand_a;
    logic [`ISSUE_XLEN-1:0]       operand_b;
    logic [`ISSUE_XLEN-1:0]       imm;
    logic [`ISSUE_TRANS_ID_W-1:0] trans_id;
  } fu_data_t;

  typedef struct packed {
    logic fwd_rs1;
    logic fwd_rs2;
  } fwd_sel_t;

endpackage

// ==== logic/issue_read_operands.sv ====
`timescale 1ns/1ns
`include "issue_consts.svh"

module issue_read_operands (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           flush_i,
  input  logic                                           stall_i,
  // from decode, held while ack is low
  input  issue_pkg::issue_entry_t                        issue_instr_i,
  input  logic                                           issue_valid_i,
  output logic                                           issue_ack_o,
  // scoreboard lookup
  output logic [`ISSUE_REG_ADDR_W-1:0]                   rs1_o,
  output logic [`ISSUE_REG_ADDR_W-1:0]                   rs2_o,
  input  issue_pkg::fwd_value_t                          rs1_fwd_i,
  input  issue_pkg::fwd_value_t                          rs2_fwd_i,
  input  issue_pkg::clobber_table_t                      rd_clobber_i,
  input  issue_pkg::unit_ready_t                         unit_ready_i,
  input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0] commit_i,
  // to execute
  output issue_pkg::fu_data_t                            fu_data_o,
  output issue_pkg::unit_valid_t                         unit_valid_o,
  output logic [`ISSUE_XLEN-1:0]                         pc_o,
  output logic                                           is_compressed_o
);

  import issue_pkg::*;

  logic [`ISSUE_XLEN-1:0] rf_a;
  logic [`ISSUE_XLEN-1:0] rf_b;
  logic [`ISSUE_XLEN-1:0] operand_a;
  logic [`ISSUE_XLEN-1:0] operand_b;
  logic [`ISSUE_XLEN-1:0] imm;
  fwd_sel_t               fwd_sel;
  logic                   mult_busy;
  logic                   accept;

  // scoreboard is polled with the raw source fields
  assign rs1_o  = issue_instr_i.rs1;
  assign rs2_o  = issue_instr_i.rs2;
  assign accept = issue_valid_i & issue_ack_o;

  issue_regfile issue_regfile_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (issue_instr_i.rs1),
    .raddr_b_i (issue_instr_i.rs2),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b),
    .commit_i  (commit_i)
  );

  issue_hazard_check issue_hazard_check_inst (
    .instr_i     (issue_instr_i),
    .valid_i     (issue_valid_i),
    .stall_i     (stall_i),
    .clobber_i   (rd_clobber_i),
    .rs1_fwd_i   (rs1_fwd_i),
    .rs2_fwd_i   (rs2_fwd_i),
    .ready_i     (unit_ready_i),
    .commit_i    (commit_i),
    .mult_busy_i (mult_busy),
    .ack_o       (issue_ack_o),
    .fwd_o       (fwd_sel)
  );

  issue_operand_select issue_operand_select_inst (
    .instr_i     (issue_instr_i),
    .fwd_i       (fwd_sel),
    .rs1_fwd_i   (rs1_fwd_i),
    .rs2_fwd_i   (rs2_fwd_i),
    .rf_a_i      (rf_a),
    .rf_b_i      (rf_b),
    .operand_a_o (operand_a),
    .operand_b_o (operand_b),
    .imm_o       (imm)
  );

  issue_dispatch issue_dispatch_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .instr_i         (issue_instr_i),
    .accept_i        (accept),
    .operand_a_i     (operand_a),
    .operand_b_i     (operand_b),
    .imm_i           (imm),
    .fu_data_o       (fu_data_o),
    .unit_valid_o    (unit_valid_o),
    .pc_o            (pc_o),
    .is_compressed_o (is_compressed_o),
    .mult_busy_o     (mult_busy)
  );

endmodule

// ==== logic/issue_regfile.sv ====
`timescale 1ns/1ns
`include "issue_consts.svh"

module issue_regfile (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // read side, rs1 and rs2
  input  logic [`ISSUE_REG_ADDR_W-1:0]                      raddr_a_i,
  input  logic [`ISSUE_REG_ADDR_W-1:0]                      raddr_b_i,
  output logic [`ISSUE_XLEN-1:0]                            rdata_a_o,
  output logic [`ISSUE_XLEN-1:0]                            rdata_b_o,
  // write side from commit
  input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0]    commit_i
);

  // register storage, x0 included but never written
  logic [`ISSUE_XLEN-1:0] regs_q [`ISSUE_NR_REGS];

  // ------------------------------
  // write ports
  // ------------------------------
  // ports applied in order so the highest index wins a collision
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < `ISSUE_NR_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
        // x0 is hard-wired, drop its writes
        if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
          regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
        end
      end
    end
  end

  // ------------------------------
  // read ports
  // ------------------------------
  // combinational, a same-cycle write is not visible yet
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// ==== verification/issue_read_operands_assert.sv ====
`timescale 1ns/1ns
`include "issue_consts.svh"

module issue_read_operands_assert (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   flush_i,
  input issue_pkg::unit_valid_t unit_valid_o,
  input issue_pkg::fu_data_t    fu_data_o
);

  // one unit at a time
  onehot_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(unit_valid_o)) else $error("more than one unit valid");

  // flush empties the id/ex stage
  flush_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> (unit_valid_o == '0)) else $error("unit valid after flush");

  known_operands: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|unit_valid_o) |-> !$isunknown({fu_data_o.operand_a, fu_data_o.operand_b}))
    else $error("unknown operand with unit valid");

endmodule

bind issue_read_operands issue_read_operands_assert issue_read_operands_assert_inst (.*);

// ==== verification/issue_read_operands_tb.sv ====
`timescale 1ns/1ns
`include "issue_consts.svh"

module issue_read_operands_tb;

  import issue_pkg::*;

  localparam int CYCLE_LIMIT = 2000;

  // one cycle worth of dut inputs
  typedef struct packed {
    issue_entry_t                       instr;
    logic                               valid;
    logic                               stall;
    logic                               flush;
    clobber_table_t                     clob;
    fwd_value_t                         f1;
    fwd_value_t                         f2;
    unit_ready_t                        rdy;
    commit_port_t [`ISSUE_NR_COMMIT-1:0] commit;
  } stim_t;

  typedef struct packed {
    logic                   ack;
    fu_data_t               fd;
    unit_valid_t            uv;
    logic [`ISSUE_XLEN-1:0] pc;
    logic                   comp;
  } expect_t;

  logic        clk_i;
  logic        rst_ni;
  stim_t       cur;
  logic        ack;
  logic [4:0]  rs1_idx;
  logic [4:0]  rs2_idx;
  fu_data_t    fu_data;
  unit_valid_t unit_valid;
  logic [31:0] pc;
  logic        is_comp;

  logic [31:0] lfsr_q;
  logic [31:0] shadow_rf [`ISSUE_NR_REGS];
  expect_t     pend;
  int          errors;
  int          checks;
  int          tests;
  int          cycles;

  issue_read_operands issue_read_operands_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (cur.flush),
    .stall_i         (cur.stall),
    .issue_instr_i   (cur.instr),
    .issue_valid_i   (cur.valid),
    .issue_ack_o     (ack),
    .rs1_o           (rs1_idx),
    .rs2_o           (rs2_idx),
    .rs1_fwd_i       (cur.f1),
    .rs2_fwd_i       (cur.f2),
    .rd_clobber_i    (cur.clob),
    .unit_ready_i    (cur.rdy),
    .commit_i        (cur.commit),
    .fu_data_o       (fu_data),
    .unit_valid_o    (unit_valid),
    .pc_o            (pc),
    .is_compressed_o (is_comp)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lsb    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (lsb) lfsr_q = lfsr_q ^ 32'ha300_0000;
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic fu_t rand_fu();
    logic [2:0] v;
    v = 3'(rand_bits(3));
    if (v == 3'd7) v = 3'd3;
    return fu_t'(v);
  endfunction

  // all free, all ready, nothing valid
  function automatic stim_t idle_stim();
    stim_t s;
    s     = '0;
    s.rdy = '1;
    return s;
  endfunction

  function automatic issue_entry_t new_instr(input fu_t fu, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [4:0] rd);
    issue_entry_t i;
    i          = '0;
    i.fu       = fu;
    i.op       = fu_op_t'(4'(rand_bits(4)));
    i.pc       = rand_bits(32);
    i.result   = rand_bits(32);
    i.trans_id = 3'(rand_bits(3));
    i.rs1      = rs1;
    i.rs2      = rs2;
    i.rd       = rd;
    return i;
  endfunction

  task automatic drive(input stim_t s);
    @(posedge clk_i);
    cur <= s;
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic expect_t predict(input stim_t s, input unit_valid_t uv_now);
    expect_t     e;
    fu_t         c1;
    fu_t         c2;
    fu_t         cd;
    logic        f1;
    logic        f2;
    logic        stall;
    logic        busy;
    logic        rd_free;
    logic [31:0] a;
    logic [31:0] b;
    c1 = s.clob[s.instr.rs1];
    c2 = s.clob[s.instr.rs2];
    cd = s.clob[s.instr.rd];
    // zimm means rs1 is data, not a source
    f1 = !s.instr.use_zimm && (c1 != NONE) && s.f1.valid && (c1 != CSR);
    f2 = (c2 != NONE) && s.f2.valid && (c2 != CSR);
    stall = s.stall || (!s.instr.use_zimm && (c1 != NONE) && !f1) || ((c2 != NONE) && !f2);
    case (s.instr.fu)
      ALU, CTRL_FLOW, CSR, MULT: busy = !s.rdy.flu;
      LOAD, STORE:               busy = !s.rdy.lsu;
      default:                   busy = 1'b0;
    endcase
    rd_free = (cd == NONE);
    for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
      if (s.commit[p].we && (s.commit[p].waddr == s.instr.rd)) rd_free = 1'b1;
    end
    e.ack = s.valid && ((!stall && !busy && rd_free) || s.instr.ex_valid || (s.instr.fu == NONE));
    // multiply owns the result bus next cycle
    if (uv_now.mult && (s.instr.fu inside {ALU, CTRL_FLOW, CSR})) e.ack = 1'b0;
    a = shadow_rf[s.instr.rs1];
    if (f1) a = s.f1.value;
    if (s.instr.use_pc) a = s.instr.pc;
    if (s.instr.use_zimm) a = {27'b0, s.instr.rs1};
    b = shadow_rf[s.instr.rs2];
    if (f2) b = s.f2.value;
    if (s.instr.use_imm && !(s.instr.fu inside {STORE, CTRL_FLOW})) b = s.instr.result;
    e.fd.fu        = s.instr.fu;
    e.fd.op        = s.instr.op;
    e.fd.operand_a = a;
    e.fd.operand_b = b;
    e.fd.imm       = s.instr.result;
    e.fd.trans_id  = s.instr.trans_id;
    e.uv           = '0;
    if (e.ack && !s.instr.ex_valid && !s.flush) begin
      case (s.instr.fu)
        ALU:         e.uv.alu    = 1'b1;
        CTRL_FLOW:   e.uv.branch = 1'b1;
        LOAD, STORE: e.uv.lsu    = 1'b1;
        MULT:        e.uv.mult   = 1'b1;
        CSR:         e.uv.csr    = 1'b1;
        default:     e.uv        = '0;
      endcase
    end
    e.pc   = s.instr.pc;
    e.comp = s.instr.is_compressed;
    return e;
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // fields shown as fu/op/a/b/imm/id
  task automatic check_fu_data(input fu_data_t got, input fu_data_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t: fu_data got %0d/%0d/%h/%h/%h/%0d expected %0d/%0d/%h/%h/%h/%0d",
               $time, got.fu, got.op, got.operand_a, got.operand_b, got.imm, got.trans_id,
               exp.fu, exp.op, exp.operand_a, exp.operand_b, exp.imm, exp.trans_id);
      errors++;
    end
  endtask

  task automatic check_unit_valid(input unit_valid_t got, input unit_valid_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t: unit_valid got %b expected %b", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_index(input logic [`ISSUE_REG_ADDR_W-1:0] got,
                             input logic [`ISSUE_REG_ADDR_W-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // mid-cycle compare, inputs and registers are settled here
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_fu_data(fu_data, pend.fd);
      check_unit_valid(unit_valid, pend.uv);
      check_word(pc, pend.pc, "pc");
      check_bit(is_comp, pend.comp, "is_compressed");
      pend = predict(cur, pend.uv);
      check_bit(ack, pend.ack, "ack");
      // scoreboard lookup indices follow the source fields
      check_index(rs1_idx, cur.instr.rs1, "rs1");
      check_index(rs2_idx, cur.instr.rs2, "rs2");
      // commit lands at the next edge
      for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
        if (cur.commit[p].we && (cur.commit[p].waddr != 0)) begin
          shadow_rf[cur.commit[p].waddr] = cur.commit[p].wdata;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic report_test(input string name, input int err_before);
    // last stimulus still owes its registered compare
    drive(idle_stim());
    @(posedge clk_i);
    tests++;
    if (errors == err_before) $display("test %s: ok", name);
    else $display("test %s: %0d mismatches", name, errors - err_before);
  endtask

  // ------------------------------
  // tests
  // ------------------------------
  task automatic test_regfile();
    stim_t      s;
    logic [4:0] r;
    logic [4:0] w1;
    int         e0;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      r  = (i == 0) ? 5'd0 : 5'(rand_bits(5));
      // second pass puts both ports on one register
      w1 = (i == 1) ? r : 5'(rand_bits(5));
      s = idle_stim();
      s.commit[0] = {1'b1, r, rand_bits(32)};
      s.commit[1] = {1'b1, w1, rand_bits(32)};
      drive(s);
      s = idle_stim();
      s.valid = 1'b1;
      s.instr = new_instr(ALU, r, w1, 5'd1);
      drive(s);
    end
    report_test("regfile", e0);
  endtask

  task automatic test_forward();
    stim_t s;
    int    e0;
    e0 = errors;
    s = idle_stim();
    s.valid = 1'b1;
    s.instr = new_instr(ALU, 5'd3, 5'd4, 5'd5);
    s.clob[3] = ALU;
    s.f1 = {rand_bits(32), 1'b1};
    drive(s);
    s.clob[4] = LOAD;
    s.f2 = {rand_bits(32), 1'b0};
    drive(s);
    s.clob[4] = NONE;
    s.clob[3] = CSR;
    drive(s);
    s.clob[3] = NONE;
    s.stall = 1'b1;
    drive(s);
    report_test("forward", e0);
  endtask

  task automatic test_waw();
    stim_t s;
    int    e0;
    e0 = errors;
    s = idle_stim();
    s.valid = 1'b1;
    s.instr = new_instr(LOAD, 5'd1, 5'd2, 5'd7);
    s.clob[7] = LOAD;
    drive(s);
    s.commit[1] = {1'b1, 5'd7, rand_bits(32)};
    drive(s);
    s.commit[1] = '0;
    s.commit[0] = {1'b1, 5'd8, rand_bits(32)};
    drive(s);
    report_test("waw", e0);
  endtask

  task automatic test_units();
    stim_t s;
    int    e0;
    e0 = errors;
    for (int f = 1; f < 7; f++) begin
      s = idle_stim();
      s.valid = 1'b1;
      s.instr = new_instr(fu_t'(3'(f)), 5'd9, 5'd10, 5'd11);
      drive(s);
      drive(idle_stim());
    end
    s.instr = new_instr(ALU, 5'd9, 5'd10, 5'd11);
    s.rdy.flu = 1'b0;
    drive(s);
    s.instr = new_instr(LOAD, 5'd9, 5'd10, 5'd11);
    s.rdy = 2'b10;
    drive(s);
    s = idle_stim();
    s.valid = 1'b1;
    s.instr = new_instr(ALU, 5'd9, 5'd10, 5'd11);
    s.instr.ex_valid = 1'b1;
    s.stall = 1'b1;
    drive(s);
    s.instr = new_instr(NONE, 5'd9, 5'd10, 5'd11);
    drive(s);
    report_test("units", e0);
  endtask

  task automatic test_select();
    stim_t s;
    int    e0;
    e0 = errors;
    s = idle_stim();
    s.valid = 1'b1;
    s.instr = new_instr(ALU, 5'd12, 5'd13, 5'd14);
    s.instr.use_pc = 1'b1;
    drive(s);
    // clobbered rs1 must not matter for zimm
    s.instr = new_instr(CSR, 5'd12, 5'd0, 5'd14);
    s.instr.use_zimm = 1'b1;
    s.clob[12] = LOAD;
    drive(s);
    s.clob[12] = NONE;
    s.instr = new_instr(ALU, 5'd12, 5'd13, 5'd14);
    s.instr.use_imm = 1'b1;
    drive(s);
    s.instr = new_instr(STORE, 5'd12, 5'd13, 5'd0);
    s.instr.use_imm = 1'b1;
    drive(s);
    report_test("select", e0);
  endtask

  task automatic test_flush_mult();
    stim_t s;
    int    e0;
    e0 = errors;
    s = idle_stim();
    s.valid = 1'b1;
    s.flush = 1'b1;
    s.instr = new_instr(ALU, 5'd1, 5'd2, 5'd3);
    drive(s);
    s.flush = 1'b0;
    s.instr = new_instr(MULT, 5'd1, 5'd2, 5'd3);
    drive(s);
    s.instr = new_instr(ALU, 5'd1, 5'd2, 5'd4);
    drive(s);
    drive(s);
    report_test("flush_mult", e0);
  endtask

  task automatic test_random(input int n);
    stim_t s;
    int    e0;
    e0 = errors;
    for (int i = 0; i < n; i++) begin
      s = idle_stim();
      s.valid = 1'(rand_bits(1));
      s.stall = (rand_bits(3) == 0);
      s.flush = (rand_bits(4) == 0);
      s.instr = new_instr(rand_fu(), 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)));
      s.instr.use_imm       = 1'(rand_bits(1));
      s.instr.use_zimm      = (rand_bits(2) == 0);
      s.instr.use_pc        = (rand_bits(2) == 0);
      s.instr.ex_valid      = (rand_bits(3) == 0);
      s.instr.is_compressed = 1'(rand_bits(1));
      if (rand_bits(2) == 0) s.clob[s.instr.rs1] = rand_fu();
      if (rand_bits(2) == 0) s.clob[s.instr.rs2] = rand_fu();
      if (rand_bits(2) == 0) s.clob[s.instr.rd] = rand_fu();
      s.f1 = {rand_bits(32), 1'(rand_bits(1))};
      s.f2 = {rand_bits(32), 1'(rand_bits(1))};
      s.rdy.flu = (rand_bits(2) != 0);
      s.rdy.lsu = (rand_bits(2) != 0);
      for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
        s.commit[p] = {1'(rand_bits(1)), 5'(rand_bits(5)), rand_bits(32)};
      end
      drive(s);
    end
    report_test("random", e0);
  endtask

  initial begin
    lfsr_q = 32'hd317;
    errors = 0;
    checks = 0;
    tests  = 0;
    cycles = 0;
    pend   = '0;
    for (int r = 0; r < `ISSUE_NR_REGS; r++) shadow_rf[r] = '0;
    cur    = idle_stim();
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_regfile();
    test_forward();
    test_waw();
    test_units();
    test_select();
    test_flush_mult();
    test_random(400);
    drive(idle_stim());
    drive(idle_stim());
    @(posedge clk_i);
    $display("tests: %0d, checks: %0d, mismatches: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
